// File: flist.f
verilog/apb_ss_pkg.sv
verilog/ahb_decode.sv
verilog/apb_execute.sv
verilog/ahb_result.sv
verilog/gpio_regs.sv
verilog/scratch_regs.sv
verilog/apb_ss_top.sv
tb/tb_apb_ss.sv

// File: run.sh
#!/bin/sh
# Build and run the AHB to APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=tb_apb_ss
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" -f flist.f -o "sim_$TOP"

./obj_dir/"sim_$TOP" | tee "$LOG"

# Pass only if the testbench printed its pass line
if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "run.sh: pass line not found in $LOG" >&2
exit 1

// File: tb/tb_apb_ss.sv
// Drives one AHB transfer at a time on falling edges; GPIO inputs change only between transfers
`timescale 1ns/1ps

module tb_apb_ss;

  // ==========================================================================
  // Test length and limits
  // ==========================================================================
  localparam int N_RAND       = 2000;
  localparam int N_DIRECTED   = 16;   // Reset reads plus word write/read pairs
  localparam int MAX_GAP      = 3;    // Idle cycles between transfers
  localparam int RESET_CYCLES = 10;
  localparam int WAIT_LIMIT   = 16;   // Guard against hready stuck low
  localparam int WATCHDOG_NS  = (N_RAND + N_DIRECTED) * (MAX_GAP + 6) * 8
                                + (RESET_CYCLES + 2) * 8;

  logic        tb_hclk10;
  logic        hresetn10;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic        hwrite;
  logic [31:0] hwdata;
  logic [15:0] gpio_in;
  logic [31:0] hrdata;
  logic        hready;
  logic        hresp;
  logic [15:0] gpio_out;
  logic [15:0] gpio_oe_n;

  // Reference model state
  logic [15:0] out_m;
  logic [15:0] oe_m;
  logic [15:0] sync_m;            // Synchronised GPIO inputs
  logic [31:0] scratch_m [4];

  integer      seed;
  int          mismatch_count;
  int          other_count;

  apb_ss_top u_dut (
    .i_hclk      (tb_hclk10),
    .i_hresetn   (hresetn10),
    .i_hsel      (hsel),
    .i_haddr     (haddr),
    .i_htrans    (htrans),
    .i_hsize     (hsize),
    .i_hwrite    (hwrite),
    .i_hwdata    (hwdata),
    .i_gpio_in   (gpio_in),
    .o_hrdata    (hrdata),
    .o_hready    (hready),
    .o_hresp     (hresp),
    .o_gpio_out  (gpio_out),
    .o_gpio_oe_n (gpio_oe_n)
  );

  always #4 tb_hclk10 = ~tb_hclk10;   // 8 ns period

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  // Byte lanes touched by a transfer, straight from the AHB size rules
  function automatic logic [3:0] lane_strobes(input logic [2:0] size, input logic [1:0] lane);
    logic [3:0] strb;
    for (int b = 0; b < 4; b++) begin
      if (size == apb_ss_pkg::HSIZE_BYTE)      strb[b] = (b == int'(lane));
      else if (size == apb_ss_pkg::HSIZE_HALF) strb[b] = ((b / 2) == int'(lane[1]));
      else                                     strb[b] = 1'b1;
    end
    return strb;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
    logic [3:0]  strb;
    logic [11:0] ofs;
    strb = lane_strobes(size, addr[1:0]);
    ofs  = {addr[11:2], 2'b00};
    if (addr[15:12] == apb_ss_pkg::SLOT_SCRATCH) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) scratch_m[addr[3:2]][8*b +: 8] = data[8*b +: 8];   // Index modulo 4
      end
    end else if (ofs == apb_ss_pkg::GPIO_OFS_OUT) begin
      if (strb[0]) out_m[7:0]  = data[7:0];
      if (strb[1]) out_m[15:8] = data[15:8];   // Upper lanes have no bits
    end else if (ofs == apb_ss_pkg::GPIO_OFS_OE) begin
      if (strb[0]) oe_m[7:0]  = data[7:0];
      if (strb[1]) oe_m[15:8] = data[15:8];
    end
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [11:0] ofs;
    ofs = {addr[11:2], 2'b00};
    if (addr[15:12] == apb_ss_pkg::SLOT_SCRATCH) return scratch_m[addr[3:2]];
    if (ofs == apb_ss_pkg::GPIO_OFS_OUT) return {16'h0000, out_m};
    if (ofs == apb_ss_pkg::GPIO_OFS_OE)  return {16'h0000, oe_m};
    if (ofs == apb_ss_pkg::GPIO_OFS_IN)  return {16'h0000, sync_m};
    return 32'h0000_0000;   // Unused GPIO offsets
  endfunction

  // ==========================================================================
  // One AHB transfer, started and finished on a falling edge
  // ==========================================================================
  task automatic run_transfer(input logic [31:0] addr, input logic [2:0] size,
                              input logic write, input logic [31:0] wdata, input string name);
    logic        err;
    logic [31:0] exp_rdata;
    int          low_cycles;
    err = (addr[31:16] != 16'h0000) ||
          ((addr[15:12] != apb_ss_pkg::SLOT_GPIO) && (addr[15:12] != apb_ss_pkg::SLOT_SCRATCH));
    exp_rdata = model_read(addr);   // State before this transfer
    if (!hready) begin
      other_count++;
      $display("Error %s: hready was low when the address phase started", name);
    end
    hsel   = 1'b1;
    haddr  = addr;
    htrans = apb_ss_pkg::HTRANS_NONSEQ;
    hsize  = size;
    hwrite = write;
    @(negedge tb_hclk10);             // Accepted at edge N
    hsel   = 1'b0;
    htrans = apb_ss_pkg::HTRANS_IDLE;
    hwdata = wdata;                   // Data phase
    low_cycles = 0;
    while (!hready && low_cycles < WAIT_LIMIT) begin
      if (!err) check_value({name, " hresp wait"}, 32'd0, {31'd0, hresp});
      if (err && low_cycles == 1) check_value({name, " hresp err1"}, 32'd1, {31'd0, hresp});
      low_cycles++;
      @(negedge tb_hclk10);
    end
    if (low_cycles == WAIT_LIMIT) begin
      other_count++;
      $display("Error %s: hready never returned high", name);
    end
    check_value({name, " wait cycles"}, err ? 32'd2 : 32'd3, low_cycles);
    if (err) begin
      check_value({name, " hresp err2"}, 32'd1, {31'd0, hresp});
      @(negedge tb_hclk10);           // Response back to OKAY
      check_value({name, " hresp after err"}, 32'd0, {31'd0, hresp});
      check_value({name, " hready after err"}, 32'd1, {31'd0, hready});
    end else begin
      check_value({name, " hresp done"}, 32'd0, {31'd0, hresp});
      if (!write) check_value({name, " hrdata"}, exp_rdata, hrdata);
      else        model_write(addr, size, wdata);
    end
    check_value({name, " gpio_out"}, {16'h0000, out_m}, {16'h0000, gpio_out});
    check_value({name, " gpio_oe_n"}, {16'h0000, ~oe_m}, {16'h0000, gpio_oe_n});
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all transfers completed");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd_data;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [15:0] region;
    logic [3:0]  slot;
    logic [9:0]  word;
    logic [1:0]  lane;
    logic [2:0]  size;
    logic [1:0]  gap;
    seed           = 32'h31bd_90ba;
    mismatch_count = 0;
    other_count    = 0;
    tb_hclk10      = 1'b0;
    hresetn10      = 1'b0;
    hsel           = 1'b0;
    haddr          = 32'h0000_0000;
    htrans         = apb_ss_pkg::HTRANS_IDLE;
    hsize          = apb_ss_pkg::HSIZE_WORD;
    hwrite         = 1'b0;
    hwdata         = 32'h0000_0000;
    gpio_in        = 16'h0000;
    out_m          = 16'h0000;
    oe_m           = 16'h0000;
    sync_m         = 16'h0000;
    for (int w = 0; w < 4; w++) scratch_m[w] = 32'h0000_0000;

    repeat (RESET_CYCLES) @(posedge tb_hclk10);
    @(negedge tb_hclk10);
    hresetn10 = 1'b1;
    @(negedge tb_hclk10);

    // ========================================================================
    // Reset state, then word write and read-back
    // ========================================================================
    check_value("reset hready", 32'd1, {31'd0, hready});
    check_value("reset hresp", 32'd0, {31'd0, hresp});
    check_value("reset gpio_oe_n", 32'h0000_ffff, {16'h0000, gpio_oe_n});
    check_value("reset gpio_out", 32'h0000_0000, {16'h0000, gpio_out});
    for (int w = 0; w < 4; w++) begin
      addr = {16'h0000, apb_ss_pkg::SLOT_SCRATCH, 8'h00, w[1:0], 2'b00};
      run_transfer(addr, apb_ss_pkg::HSIZE_WORD, 1'b0, 32'h0000_0000, "reset_read");
    end
    for (int d = 0; d < 6; d++) begin
      // GPIO OUT and OE, then the four scratch words
      addr  = (d < 2) ? 32'(4 * d) : 32'h0000_1000 + 32'(4 * (d - 2));
      wdata = $random(seed);
      run_transfer(addr, apb_ss_pkg::HSIZE_WORD, 1'b1, wdata, "word_write");
      run_transfer(addr, apb_ss_pkg::HSIZE_WORD, 1'b0, 32'h0000_0000, "word_read");
    end

    // ========================================================================
    // Random transfers
    // ========================================================================
    for (int t = 0; t < N_RAND; t++) begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      region   = 16'h0000;
      word     = 10'h000;
      if (rnd[3:0] < 4'd7) begin
        slot = apb_ss_pkg::SLOT_GPIO;
        word = {8'h00, rnd[5:4]};          // OUT, OE, IN or an unused offset
      end else if (rnd[3:0] < 4'd14) begin
        slot = apb_ss_pkg::SLOT_SCRATCH;
        word = rnd[13:4];                  // Aliases modulo 4
      end else if (rnd[3:0] == 4'd14) begin
        slot = (rnd[19:16] < 4'd2) ? rnd[19:16] + 4'd2 : rnd[19:16];   // Unmapped slot
      end else begin
        region = rnd_data[31:16] | 16'h0001;
        slot   = rnd[16] ? apb_ss_pkg::SLOT_SCRATCH : apb_ss_pkg::SLOT_GPIO;
      end
      case (rnd[21:20])
        2'd0: begin
          size  = apb_ss_pkg::HSIZE_BYTE;
          lane  = rnd[23:22];
          wdata = {4{rnd_data[7:0]}};        // Low byte on every lane
        end
        2'd1: begin
          size  = apb_ss_pkg::HSIZE_HALF;
          lane  = {rnd[22], 1'b0};
          wdata = {2{rnd_data[15:0]}};
        end
        default: begin
          size  = apb_ss_pkg::HSIZE_WORD;
          lane  = 2'b00;
          wdata = rnd_data;
        end
      endcase
      addr = {region, slot, word, lane};
      run_transfer(addr, size, rnd[24], wdata, $sformatf("rand%0d", t));
      gap = rnd[26:25];
      if (rnd[29:28] == 2'b11) begin
        rnd     = $random(seed);
        gpio_in = rnd[15:0];
        sync_m  = rnd[15:0];
        repeat (3) @(negedge tb_hclk10);   // Through the synchroniser before any read
      end else begin
        repeat (gap) @(negedge tb_hclk10);
      end
    end

    $display("Error counts: mismatches=%0d other=%0d", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/apb_ss_top.sv
// AHB-lite to APB subsystem, single clock and synchronous low reset; GPIO in slot 0, scratch 1
`timescale 1ns/1ps

module apb_ss_top (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_hsel,
  input  logic [apb_ss_pkg::ADDR_W-1:0]   i_haddr,
  input  logic [1:0]                      i_htrans,
  input  logic [2:0]                      i_hsize,
  input  logic                            i_hwrite,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_hwdata,
  input  logic [apb_ss_pkg::GPIO_W-1:0]   i_gpio_in,
  output logic [apb_ss_pkg::DATA_W-1:0]   o_hrdata,
  output logic                            o_hready,
  output logic                            o_hresp,
  output logic [apb_ss_pkg::GPIO_W-1:0]   o_gpio_out,
  output logic [apb_ss_pkg::GPIO_W-1:0]   o_gpio_oe_n
);

  // Decoded request
  logic                            req, err, write;
  logic [apb_ss_pkg::SLOT_W-1:0]   slot;
  logic [apb_ss_pkg::ADDR_W-1:0]   req_addr;
  logic [apb_ss_pkg::STRB_W-1:0]   strb;

  // APB bus
  logic                            psel_gpio, psel_scratch, penable, pwrite;
  logic [apb_ss_pkg::ADDR_W-1:0]   paddr;
  logic [apb_ss_pkg::DATA_W-1:0]   pwdata, prdata_gpio, prdata_scratch;
  logic [apb_ss_pkg::STRB_W-1:0]   pstrb;

  // Completion
  logic                            done;
  logic [apb_ss_pkg::SLOT_W-1:0]   done_slot;

  ahb_decode u_decode (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_hsel (i_hsel), .i_haddr (i_haddr), .i_htrans (i_htrans),
    .i_hsize (i_hsize), .i_hwrite (i_hwrite), .i_hready (o_hready),   // Own hready
    .o_req (req), .o_err (err), .o_slot (slot),
    .o_paddr (req_addr), .o_write (write), .o_strb (strb)
  );

  apb_execute u_execute (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_req (req), .i_err (err), .i_slot (slot), .i_paddr (req_addr),
    .i_write (write), .i_strb (strb), .i_hwdata (i_hwdata),
    .o_psel_gpio (psel_gpio), .o_psel_scratch (psel_scratch), .o_penable (penable),
    .o_paddr (paddr), .o_pwrite (pwrite), .o_pwdata (pwdata), .o_pstrb (pstrb),
    .o_done (done), .o_done_slot (done_slot)
  );

  ahb_result u_result (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_req (req), .i_err (err), .i_done (done), .i_done_slot (done_slot),
    .i_prdata_gpio (prdata_gpio), .i_prdata_scratch (prdata_scratch),
    .o_hrdata (o_hrdata), .o_hready (o_hready), .o_hresp (o_hresp)
  );

  gpio_regs u_gpio (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_psel (psel_gpio), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata), .i_pstrb (pstrb), .i_gpio_in (i_gpio_in),
    .o_prdata (prdata_gpio), .o_gpio_out (o_gpio_out), .o_gpio_oe_n (o_gpio_oe_n)
  );

  scratch_regs u_scratch (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_psel (psel_scratch), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata), .i_pstrb (pstrb),
    .o_prdata (prdata_scratch)
  );

endmodule

// File: verilog/scratch_regs.sv
// Four scratch words cleared by reset; upper address bits alias, word index is taken modulo 4
`timescale 1ns/1ps

module scratch_regs (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_psel,
  input  logic                            i_penable,
  input  logic                            i_pwrite,
  input  logic [apb_ss_pkg::ADDR_W-1:0]   i_paddr,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_pwdata,
  input  logic [apb_ss_pkg::STRB_W-1:0]   i_pstrb,
  output logic [apb_ss_pkg::DATA_W-1:0]   o_prdata
);

  logic [apb_ss_pkg::SCRATCH_IDX_W-1:0] idx;
  logic                                 wr_en;
  logic [apb_ss_pkg::DATA_W-1:0]        mem_q [apb_ss_pkg::SCRATCH_WORDS];

  assign idx   = i_paddr[2 +: apb_ss_pkg::SCRATCH_IDX_W];   // Word select
  assign wr_en = i_psel && i_penable && i_pwrite;

  // Lane-strobed writes
  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      for (int w = 0; w < apb_ss_pkg::SCRATCH_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < apb_ss_pkg::STRB_W; b++) begin
        if (i_pstrb[b]) mem_q[idx][8*b +: 8] <= i_pwdata[8*b +: 8];
      end
    end
  end

  assign o_prdata = mem_q[idx];   // Combinational read

endmodule

// File: verilog/gpio_regs.sv
// 16-pin GPIO, lanes 2 and 3 ignored; OE register is active high, pin enable is active low
`timescale 1ns/1ps

module gpio_regs (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_psel,
  input  logic                            i_penable,
  input  logic                            i_pwrite,
  input  logic [apb_ss_pkg::ADDR_W-1:0]   i_paddr,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_pwdata,
  input  logic [apb_ss_pkg::STRB_W-1:0]   i_pstrb,
  input  logic [apb_ss_pkg::GPIO_W-1:0]   i_gpio_in,
  output logic [apb_ss_pkg::DATA_W-1:0]   o_prdata,
  output logic [apb_ss_pkg::GPIO_W-1:0]   o_gpio_out,
  output logic [apb_ss_pkg::GPIO_W-1:0]   o_gpio_oe_n
);

  logic [apb_ss_pkg::OFS_W-1:0]   ofs;
  logic                           wr_en;
  logic [apb_ss_pkg::GPIO_W-1:0]  out_q;
  logic [apb_ss_pkg::GPIO_W-1:0]  oe_q;
  logic [apb_ss_pkg::GPIO_W-1:0]  sync1_q;
  logic [apb_ss_pkg::GPIO_W-1:0]  sync2_q;   // Value seen by IN reads

  assign ofs   = {i_paddr[apb_ss_pkg::OFS_W-1:2], 2'b00};   // Word aligned
  assign wr_en = i_psel && i_penable && i_pwrite;            // End of access phase

  // ==========================================================================
  // Output and enable registers
  // ==========================================================================
  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      out_q <= '0;
      oe_q  <= '0;   // All pins tristated
    end else if (wr_en) begin
      for (int b = 0; b < apb_ss_pkg::GPIO_W / 8; b++) begin
        if (i_pstrb[b]) begin
          if (ofs == apb_ss_pkg::GPIO_OFS_OUT) out_q[8*b +: 8] <= i_pwdata[8*b +: 8];
          if (ofs == apb_ss_pkg::GPIO_OFS_OE)  oe_q[8*b +: 8]  <= i_pwdata[8*b +: 8];
        end
      end
    end
  end

  // Two-flop input synchroniser
  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
    end
  end

  // Read mux, unused offsets read zero
  always_comb begin
    o_prdata = '0;
    case (ofs)
      apb_ss_pkg::GPIO_OFS_OUT: o_prdata[apb_ss_pkg::GPIO_W-1:0] = out_q;
      apb_ss_pkg::GPIO_OFS_OE:  o_prdata[apb_ss_pkg::GPIO_W-1:0] = oe_q;
      apb_ss_pkg::GPIO_OFS_IN:  o_prdata[apb_ss_pkg::GPIO_W-1:0] = sync2_q;
      default:                  o_prdata = '0;
    endcase
  end

  assign o_gpio_out  = out_q;
  assign o_gpio_oe_n = ~oe_q;   // Pin driver enable, low active

endmodule

// File: verilog/ahb_result.sv
// Drives hready and hresp for one transfer in flight; hrdata is only meaningful after a read
`timescale 1ns/1ps

module ahb_result (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_req,
  input  logic                            i_err,
  input  logic                            i_done,
  input  logic [apb_ss_pkg::SLOT_W-1:0]   i_done_slot,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_prdata_gpio,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_prdata_scratch,
  output logic [apb_ss_pkg::DATA_W-1:0]   o_hrdata,
  output logic                            o_hready,
  output logic                            o_hresp
);

  logic busy_q;   // APB access under way
  logic err1_q;   // First error cycle, hready low
  logic err2_q;   // Second error cycle, hready high

  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      busy_q <= 1'b0;
      err1_q <= 1'b0;
      err2_q <= 1'b0;
    end else begin
      err1_q <= i_req && i_err;
      err2_q <= err1_q;
      if (i_req && !i_err) busy_q <= 1'b1;
      else if (i_done)     busy_q <= 1'b0;
    end
  end

  // Read data picked by the slot that just finished
  always_ff @(posedge i_hclk) begin
    if (i_done) begin
      case (i_done_slot)
        apb_ss_pkg::SLOT_SCRATCH: o_hrdata <= i_prdata_scratch;
        default:                  o_hrdata <= i_prdata_gpio;
      endcase
    end
  end

  assign o_hready = !(i_req || busy_q || err1_q);   // Low from accept to done
  assign o_hresp  = (err1_q || err2_q) ? apb_ss_pkg::HRESP_ERROR : apb_ss_pkg::HRESP_OKAY;

  // Two-cycle error response
  a_err_two_cycle: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    ((o_hresp == apb_ss_pkg::HRESP_ERROR) && o_hready) |->
      $past((o_hresp == apb_ss_pkg::HRESP_ERROR) && !o_hready));

endmodule

// File: verilog/apb_execute.sv
// Two-phase APB master; no pready or pslverr, so every access is exactly setup plus one access
`timescale 1ns/1ps

module apb_execute (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_req,
  input  logic                            i_err,
  input  logic [apb_ss_pkg::SLOT_W-1:0]   i_slot,
  input  logic [apb_ss_pkg::ADDR_W-1:0]   i_paddr,
  input  logic                            i_write,
  input  logic [apb_ss_pkg::STRB_W-1:0]   i_strb,
  input  logic [apb_ss_pkg::DATA_W-1:0]   i_hwdata,
  output logic                            o_psel_gpio,
  output logic                            o_psel_scratch,
  output logic                            o_penable,
  output logic [apb_ss_pkg::ADDR_W-1:0]   o_paddr,
  output logic                            o_pwrite,
  output logic [apb_ss_pkg::DATA_W-1:0]   o_pwdata,
  output logic [apb_ss_pkg::STRB_W-1:0]   o_pstrb,
  output logic                            o_done,
  output logic [apb_ss_pkg::SLOT_W-1:0]   o_done_slot
);

  logic [1:0] state_q;
  logic       start;

  // Error requests never reach the APB side
  assign start = (state_q == apb_ss_pkg::ST_IDLE) && i_req && !i_err;

  // ==========================================================================
  // Sequencer
  // ==========================================================================
  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      state_q        <= apb_ss_pkg::ST_IDLE;
      o_psel_gpio    <= 1'b0;
      o_psel_scratch <= 1'b0;
      o_penable      <= 1'b0;
    end else begin
      case (state_q)
        apb_ss_pkg::ST_IDLE: begin
          if (start) begin
            state_q        <= apb_ss_pkg::ST_SETUP;
            o_psel_gpio    <= (i_slot == apb_ss_pkg::SLOT_GPIO);
            o_psel_scratch <= (i_slot == apb_ss_pkg::SLOT_SCRATCH);
          end
        end
        apb_ss_pkg::ST_SETUP: begin
          state_q   <= apb_ss_pkg::ST_ACCESS;
          o_penable <= 1'b1;                  // Access phase
        end
        apb_ss_pkg::ST_ACCESS: begin
          state_q        <= apb_ss_pkg::ST_IDLE;  // No wait states
          o_psel_gpio    <= 1'b0;
          o_psel_scratch <= 1'b0;
          o_penable      <= 1'b0;
        end
        default: begin
          state_q <= apb_ss_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Address, data and strobes, stable through setup and access
  always_ff @(posedge i_hclk) begin
    if (start) begin
      o_paddr     <= {16'h0000, i_paddr[15:0]};   // Slot and offset only
      o_pwrite    <= i_write;
      o_pwdata    <= i_hwdata;                    // Data phase of the AHB transfer
      o_pstrb     <= i_write ? i_strb : '0;       // APB reads carry no strobes
      o_done_slot <= i_slot;
    end
  end

  // Peripherals and result both act at the edge leaving ACCESS
  assign o_done = (state_q == apb_ss_pkg::ST_ACCESS);

  // ==========================================================================
  // APB protocol checks
  // ==========================================================================
  a_penable_psel: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    o_penable |-> (o_psel_gpio || o_psel_scratch));

  a_one_psel: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    !(o_psel_gpio && o_psel_scratch));

endmodule

// File: verilog/ahb_decode.sv
// Accepts one AHB-lite single transfer at a time; SEQ treated as NONSEQ; no hprot or locking
`timescale 1ns/1ps

module ahb_decode (
  input  logic                            i_hclk,
  input  logic                            i_hresetn,
  input  logic                            i_hsel,
  input  logic [apb_ss_pkg::ADDR_W-1:0]   i_haddr,
  input  logic [1:0]                      i_htrans,
  input  logic [2:0]                      i_hsize,
  input  logic                            i_hwrite,
  input  logic                            i_hready,
  output logic                            o_req,
  output logic                            o_err,
  output logic [apb_ss_pkg::SLOT_W-1:0]   o_slot,
  output logic [apb_ss_pkg::ADDR_W-1:0]   o_paddr,
  output logic                            o_write,
  output logic [apb_ss_pkg::STRB_W-1:0]   o_strb
);

  apb_ss_pkg::ahb_addr_u              addr;
  logic                               trans_valid;
  logic                               accept;
  logic                               map_err;
  logic [apb_ss_pkg::STRB_W-1:0]      strb;

  assign addr.raw = i_haddr;   // Field view used below

  // Only NONSEQ and SEQ carry a transfer
  always_comb begin
    case (i_htrans)
      apb_ss_pkg::HTRANS_NONSEQ,
      apb_ss_pkg::HTRANS_SEQ:    trans_valid = 1'b1;
      apb_ss_pkg::HTRANS_IDLE,
      apb_ss_pkg::HTRANS_BUSY:   trans_valid = 1'b0;
      default:                   trans_valid = 1'b0;
    endcase
  end

  assign accept = i_hsel && trans_valid && i_hready;

  // Unmapped region or slot
  assign map_err = (addr.f.region != '0) ||
                   !((addr.f.slot == apb_ss_pkg::SLOT_GPIO) ||
                     (addr.f.slot == apb_ss_pkg::SLOT_SCRATCH));

  // Byte strobes from size and lane
  always_comb begin
    case (i_hsize)
      apb_ss_pkg::HSIZE_BYTE: strb = 4'b0001 << addr.f.lane;
      apb_ss_pkg::HSIZE_HALF: strb = addr.f.lane[1] ? 4'b1100 : 4'b0011;
      apb_ss_pkg::HSIZE_WORD: strb = 4'b1111;
      default:                strb = 4'b1111;   // Flagged by assertion below
    endcase
  end

  // Request pulse and error flag
  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      o_req <= 1'b0;
      o_err <= 1'b0;
    end else begin
      o_req <= accept;                   // One cycle only
      if (accept) o_err <= map_err;
    end
  end

  // Request payload, held until the next accept
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      o_slot  <= addr.f.slot;
      o_paddr <= addr.raw;
      o_write <= i_hwrite;
      o_strb  <= strb;
    end
  end

  // ==========================================================================
  // Transfer checks
  // ==========================================================================
  a_size_max: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    accept |-> (i_hsize <= apb_ss_pkg::HSIZE_WORD));

  a_half_align: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    (accept && (i_hsize == apb_ss_pkg::HSIZE_HALF)) |-> !addr.f.lane[0]);

endmodule

// File: verilog/apb_ss_pkg.sv
// Single AHB-lite master assumed; only slots 0 and 1 are mapped; 1-bit hresp; word-wide APB
package apb_ss_pkg;

  // ==========================================================================
  // Bus widths
  // ==========================================================================
  localparam int ADDR_W = 32;            // AHB and APB address
  localparam int DATA_W = 32;            // AHB and APB data
  localparam int STRB_W = DATA_W / 8;    // One strobe per byte lane
  localparam int GPIO_W = 16;            // GPIO pin count
  localparam int SLOT_W = 4;             // Peripheral slot field
  localparam int OFS_W  = 12;            // Byte offset inside a slot

  // ==========================================================================
  // Address map
  // ==========================================================================
  localparam logic [SLOT_W-1:0] SLOT_GPIO    = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_SCRATCH = 4'd1;

  // GPIO register offsets, byte addressed
  localparam logic [OFS_W-1:0] GPIO_OFS_OUT = 12'h000;
  localparam logic [OFS_W-1:0] GPIO_OFS_OE  = 12'h004;  // Active high here, pin is inverted
  localparam logic [OFS_W-1:0] GPIO_OFS_IN  = 12'h008;  // Read only

  localparam int SCRATCH_WORDS = 4;
  localparam int SCRATCH_IDX_W = $clog2(SCRATCH_WORDS);

  // AHB transfer and size codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // APB sequencer states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  // One AHB address, either as a raw word or split into map fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [15:0] region;   // Must be zero
      logic [3:0]  slot;     // Peripheral select
      logic [9:0]  word;     // Register word index
      logic [1:0]  lane;     // Byte lane
    } f;
  } ahb_addr_u;

endpackage
